/* pipe_pkg.sv */
`default_nettype none

package pipe_pkg;

  // token kinds seen by the hazard logic
  typedef enum logic [2:0] {
    OP_ALU,
    OP_LOAD,
    OP_STORE,
    OP_MUL,
    OP_JUMP,
    OP_TRAP
  } op_t;

  typedef logic [4:0]  reg_idx_t;    // x0..x31
  typedef logic [31:0] word_t;
  typedef logic [7:0]  tag_t;        // sequence number from the source
  typedef logic [5:0]  stage_vec_t;  // [0] pc up to [4] mem_wb, [5] spare

  // abstract instruction, 92 bits
  typedef struct packed {
    logic     valid;  // low means bubble
    tag_t     tag;
    op_t      op;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    logic     taken;  // jump redirects fetch
    word_t    opa;    // mem address, later the result
    word_t    opb;    // store data or multiplier
  } token_t;

  // stall patterns per hazard
  localparam stage_vec_t LOAD_USE_STALL = 6'b000011;
  localparam stage_vec_t MUL_STALL      = 6'b000111;
  localparam stage_vec_t RAM_STALL      = 6'b001111;
  localparam stage_vec_t JUMP_STALL     = 6'b000000;
  localparam stage_vec_t TRAP_STALL     = 6'b000000;

  // flush patterns, set bit loads a bubble
  localparam stage_vec_t LOAD_USE_FLUSH = 6'b000100;
  localparam stage_vec_t MUL_FLUSH      = 6'b001000;
  localparam stage_vec_t RAM_FLUSH      = 6'b010000;
  localparam stage_vec_t JUMP_FLUSH     = 6'b000110;
  localparam stage_vec_t TRAP_FLUSH     = 6'b001110;
  localparam stage_vec_t RESET_FLUSH    = 6'b011111;  // every stage

  localparam word_t MUL_CYCLES = 32'd32;  // one step per multiplier bit

endpackage

`default_nettype wire

/* pipeline_control.sv */
`timescale 1ns/1ps
`default_nettype none

// hazard requests in, per-stage stall and flush out
// pure combinational, later stage wins
module pipeline_control (
  input  wire                  rst,
  input  wire                  ram_stall_if_i,   // fetch side busy
  input  wire                  ram_stall_mem_i,  // data port pending
  input  wire                  load_use_i,       // raised in id
  input  wire                  jump_i,           // taken jump in ex
  input  wire                  mul_busy_i,       // multiplier holds ex
  input  wire                  trap_i,           // trap in wb
  output pipe_pkg::stage_vec_t stall_o,
  output pipe_pkg::stage_vec_t flush_o
);

  logic ram_req;

  assign ram_req = ram_stall_if_i | ram_stall_mem_i;  // both memories share one pattern

  always_comb begin
    if (rst) begin
      stall_o = '0;
      flush_o = pipe_pkg::RESET_FLUSH;  // empty the whole pipe
    end else if (ram_req) begin
      // freeze pc..ex_mem, bubble into mem_wb
      stall_o = pipe_pkg::RAM_STALL;
      flush_o = pipe_pkg::RAM_FLUSH;
    end else if (trap_i) begin
      stall_o = pipe_pkg::TRAP_STALL;
      flush_o = pipe_pkg::TRAP_FLUSH;  // drop younger tokens
    end else if (jump_i) begin
      stall_o = pipe_pkg::JUMP_STALL;
      flush_o = pipe_pkg::JUMP_FLUSH;  // two wrong-path tokens
    end else if (mul_busy_i) begin
      // hold ex and everything older in fetch order
      stall_o = pipe_pkg::MUL_STALL;
      flush_o = pipe_pkg::MUL_FLUSH;
    end else if (load_use_i) begin
      stall_o = pipe_pkg::LOAD_USE_STALL;
      flush_o = pipe_pkg::LOAD_USE_FLUSH;  // one bubble into ex
    end else begin
      stall_o = '0;  // free flow
      flush_o = '0;
    end
  end

endmodule

`default_nettype wire

/* load_use_detect.sv */
`timescale 1ns/1ps
`default_nettype none

// load in ex whose rd feeds the token now in id
module load_use_detect (
  input  wire pipe_pkg::token_t id_tok_i,
  input  wire pipe_pkg::token_t ex_tok_i,
  output logic                  hazard_o
);

  logic ex_load;
  logic rs1_hit;
  logic rs2_hit;

  // x0 never carries a dependency
  assign ex_load = ex_tok_i.valid && (ex_tok_i.op == pipe_pkg::OP_LOAD)
                   && (ex_tok_i.rd != '0);

  assign rs1_hit = (id_tok_i.rs1 == ex_tok_i.rd);
  assign rs2_hit = (id_tok_i.rs2 == ex_tok_i.rd);

  // bubble in id never waits
  assign hazard_o = ex_load && id_tok_i.valid && (rs1_hit || rs2_hit);

endmodule

`default_nettype wire

/* muldiv_iter.sv */
`timescale 1ns/1ps
`default_nettype none

// shift-add multiplier, holds ex until the product is ready
module muldiv_iter (
  input  wire                   clk,
  input  wire                   rst,
  input  wire pipe_pkg::token_t ex_tok_i,
  output logic                  busy_o,
  output pipe_pkg::word_t       product_o
);

  typedef enum logic [1:0] {S_IDLE, S_RUN, S_DONE} state_t;

  state_t           state_q;
  pipe_pkg::word_t  cnt_q;     // steps taken
  pipe_pkg::tag_t   tag_q;     // token being multiplied
  pipe_pkg::word_t  acc_q;     // partial product
  pipe_pkg::word_t  mcand_q;   // shifts left
  pipe_pkg::word_t  mplier_q;  // shifts right
  logic             mul_tok;
  logic             same_tok;
  logic             start;

  assign mul_tok  = ex_tok_i.valid && (ex_tok_i.op == pipe_pkg::OP_MUL);
  assign same_tok = mul_tok && (ex_tok_i.tag == tag_q);
  // a new mul can follow straight after done
  assign start = mul_tok && ((state_q == S_IDLE) || ((state_q == S_DONE) && !same_tok));

  assign busy_o    = start || (state_q == S_RUN);  // done releases ex
  assign product_o = acc_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= S_IDLE;
      cnt_q   <= '0;
      tag_q   <= '0;
    end else begin
      case (state_q)
        S_IDLE, S_DONE: begin
          if (start) begin
            state_q <= S_RUN;
            cnt_q   <= '0;
            tag_q   <= ex_tok_i.tag;
          end else if (!same_tok) begin
            state_q <= S_IDLE;  // token left ex
          end
        end
        S_RUN: begin
          cnt_q <= cnt_q + 1'b1;
          if (!same_tok) state_q <= S_IDLE;  // flushed by a trap
          else if (cnt_q == pipe_pkg::MUL_CYCLES - 1'b1) state_q <= S_DONE;
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // datapath, one multiplier bit per cycle
  always_ff @(posedge clk) begin
    if (start) begin
      acc_q    <= '0;
      mcand_q  <= ex_tok_i.opa;
      mplier_q <= ex_tok_i.opb;
    end else if (state_q == S_RUN) begin
      if (mplier_q[0]) acc_q <= acc_q + mcand_q;  // wraps to low 32 bits
      mcand_q  <= mcand_q << 1;
      mplier_q <= mplier_q >> 1;
    end
  end

endmodule

`default_nettype wire

/* dmem_port.sv */
`timescale 1ns/1ps
`default_nettype none

// four-phase req/ack master for load and store in mem
module dmem_port (
  input  wire                   clk,
  input  wire                   rst,
  input  wire pipe_pkg::token_t mem_tok_i,
  input  wire                   dmem_ack_i,
  input  wire pipe_pkg::word_t  dmem_rdata_i,
  output logic                  stall_o,
  output pipe_pkg::word_t       rdata_o,
  output logic                  dmem_req_o,
  output logic                  dmem_we_o,
  output pipe_pkg::word_t       dmem_addr_o,
  output pipe_pkg::word_t       dmem_wdata_o
);

  typedef enum logic [1:0] {S_IDLE, S_REQ, S_WAIT_LOW, S_DONE} state_t;

  state_t          state_q;
  pipe_pkg::tag_t  tag_q;  // token served by the last transfer
  logic            mem_acc;
  logic            same_tok;
  logic            pending;
  logic            start;

  assign mem_acc  = mem_tok_i.valid
                    && ((mem_tok_i.op == pipe_pkg::OP_LOAD) || (mem_tok_i.op == pipe_pkg::OP_STORE));
  assign same_tok = mem_acc && (mem_tok_i.tag == tag_q);
  // done once per token, even if mem stays held
  assign pending  = mem_acc && !((state_q == S_DONE) && same_tok);
  assign start    = pending && ((state_q == S_IDLE) || (state_q == S_DONE));

  assign stall_o    = pending;
  assign dmem_req_o = (state_q == S_REQ);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= S_IDLE;
      tag_q   <= '0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (start) state_q <= S_REQ;
        end
        S_REQ: begin
          if (dmem_ack_i) state_q <= S_WAIT_LOW;  // drop req next
        end
        S_WAIT_LOW: begin
          if (!dmem_ack_i) state_q <= S_DONE;  // handshake closed
        end
        S_DONE: begin
          if (start) state_q <= S_REQ;  // back to back access
          else if (!same_tok) state_q <= S_IDLE;
        end
        default: state_q <= S_IDLE;
      endcase
      if (start) tag_q <= mem_tok_i.tag;
    end
  end

  // request fields stay stable for the whole transfer
  always_ff @(posedge clk) begin
    if (start) begin
      dmem_addr_o  <= mem_tok_i.opa;
      dmem_wdata_o <= mem_tok_i.opb;
      dmem_we_o    <= (mem_tok_i.op == pipe_pkg::OP_STORE);
    end
    if ((state_q == S_REQ) && dmem_ack_i) rdata_o <= dmem_rdata_i;
  end

endmodule

`default_nettype wire

/* stage_regs.sv */
`timescale 1ns/1ps
`default_nettype none

// pc, if_id, id_ex, ex_mem and mem_wb token registers
// flush beats stall, stall beats load
module stage_regs (
  input  wire                       clk,
  input  wire pipe_pkg::token_t     fetch_i,
  input  wire pipe_pkg::stage_vec_t stall_i,
  input  wire pipe_pkg::stage_vec_t flush_i,
  input  wire pipe_pkg::word_t      product_i,  // from the multiplier
  input  wire pipe_pkg::word_t      rdata_i,    // from the data port
  output pipe_pkg::token_t          id_tok_o,
  output pipe_pkg::token_t          ex_tok_o,
  output pipe_pkg::token_t          mem_tok_o,
  output pipe_pkg::token_t          wb_tok_o
);

  pipe_pkg::token_t stage_d [5];  // next value per register
  pipe_pkg::token_t stage_q [5];  // index matches the stall bit
  logic             ex_mul;
  logic             mem_load;

  assign ex_mul   = stage_q[2].valid && (stage_q[2].op == pipe_pkg::OP_MUL);
  assign mem_load = stage_q[3].valid && (stage_q[3].op == pipe_pkg::OP_LOAD);

  always_comb begin
    stage_d[0] = fetch_i;
    stage_d[1] = stage_q[0];
    stage_d[2] = stage_q[1];
    stage_d[3] = stage_q[2];
    stage_d[4] = stage_q[3];
    // results ride in opa
    if (ex_mul) stage_d[3].opa = product_i;
    if (mem_load) stage_d[4].opa = rdata_i;
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < 5; i++) begin
      if (flush_i[i]) begin
        stage_q[i] <= '0;  // bubble
      end else if (!stall_i[i]) begin
        stage_q[i] <= stage_d[i];
      end
    end
  end

  assign id_tok_o  = stage_q[1];
  assign ex_tok_o  = stage_q[2];
  assign mem_tok_o = stage_q[3];
  assign wb_tok_o  = stage_q[4];  // retire point

endmodule

`default_nettype wire

/* pipe_hazard_top.sv */
`timescale 1ns/1ps
`default_nettype none

module pipe_hazard_top (
  input  wire                   clk,
  input  wire                   rst,
  input  wire pipe_pkg::token_t fetch_i,
  input  wire                   imem_busy_i,  // fetch stall stand-in
  input  wire                   dmem_ack_i,
  input  wire pipe_pkg::word_t  dmem_rdata_i,
  output logic                  fetch_ready_o,
  output pipe_pkg::token_t      retire_o,
  output logic                  dmem_req_o,
  output logic                  dmem_we_o,
  output pipe_pkg::word_t       dmem_addr_o,
  output pipe_pkg::word_t       dmem_wdata_o
);

  pipe_pkg::stage_vec_t stall;
  pipe_pkg::stage_vec_t flush;
  pipe_pkg::token_t     id_tok;
  pipe_pkg::token_t     ex_tok;
  pipe_pkg::token_t     mem_tok;
  pipe_pkg::token_t     wb_tok;
  pipe_pkg::word_t      product;
  pipe_pkg::word_t      rdata;
  logic                 load_use;
  logic                 mul_busy;
  logic                 ram_stall_mem;
  logic                 jump_req;
  logic                 trap_req;

  // redirect decided in ex, trap taken at wb
  assign jump_req = ex_tok.valid && (ex_tok.op == pipe_pkg::OP_JUMP) && ex_tok.taken;
  assign trap_req = wb_tok.valid && (wb_tok.op == pipe_pkg::OP_TRAP);

  assign fetch_ready_o = !stall[0];  // pc hold blocks fetch
  assign retire_o      = wb_tok;

  pipeline_control u_ctrl (
    .rst             (rst),
    .ram_stall_if_i  (imem_busy_i),
    .ram_stall_mem_i (ram_stall_mem),
    .load_use_i      (load_use),
    .jump_i          (jump_req),
    .mul_busy_i      (mul_busy),
    .trap_i          (trap_req),
    .stall_o         (stall),
    .flush_o         (flush)
  );

  load_use_detect u_lud (.id_tok_i(id_tok), .ex_tok_i(ex_tok), .hazard_o(load_use));

  muldiv_iter u_mul (
    .clk       (clk),
    .rst       (rst),
    .ex_tok_i  (ex_tok),
    .busy_o    (mul_busy),
    .product_o (product)
  );

  dmem_port u_dmem (
    .clk          (clk),
    .rst          (rst),
    .mem_tok_i    (mem_tok),
    .dmem_ack_i   (dmem_ack_i),
    .dmem_rdata_i (dmem_rdata_i),
    .stall_o      (ram_stall_mem),
    .rdata_o      (rdata),
    .dmem_req_o   (dmem_req_o),
    .dmem_we_o    (dmem_we_o),
    .dmem_addr_o  (dmem_addr_o),
    .dmem_wdata_o (dmem_wdata_o)
  );

  stage_regs u_regs (
    .clk       (clk),
    .fetch_i   (fetch_i),
    .stall_i   (stall),
    .flush_i   (flush),  // reset empties the pipe through here
    .product_i (product),
    .rdata_i   (rdata),
    .id_tok_o  (id_tok),
    .ex_tok_o  (ex_tok),
    .mem_tok_o (mem_tok),
    .wb_tok_o  (wb_tok)
  );

endmodule

`default_nettype wire

/* tb_pipe_hazard.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_pipe_hazard;

  localparam logic [2:0] G_ALU  = 3'd0;
  localparam logic [2:0] G_LU   = 3'd1;
  localparam logic [2:0] G_JMP  = 3'd2;
  localparam logic [2:0] G_MUL  = 3'd3;
  localparam logic [2:0] G_MEM  = 3'd4;
  localparam logic [2:0] G_TRAP = 3'd5;
  localparam pipe_pkg::word_t RDATA_KEY = 32'h5a5a_0f0f;  // memory model read data = addr ^ key

  typedef struct packed {
    pipe_pkg::token_t tok;
    logic             retires;  // expected at retire
    logic [2:0]       grp;
    logic [7:0]       lat;      // edges from accept to retire, 0 skips
    logic [7:0]       gap;      // cycles since previous retire, 0 skips
  } entry_t;

  typedef struct packed {
    pipe_pkg::tag_t  tag;
    pipe_pkg::word_t opa;  // result field
    logic [2:0]      grp;
    logic [7:0]      lat;
    logic [7:0]      gap;
  } exp_t;

  typedef struct packed {
    logic [2:0]      grp;
    logic            we;
    pipe_pkg::word_t addr;
    pipe_pkg::word_t wdata;
  } access_t;

  logic             clk;
  logic             rst;
  pipe_pkg::token_t fetch_i;
  logic             imem_busy_i;
  logic             dmem_ack_i;
  pipe_pkg::word_t  dmem_rdata_i;
  logic             fetch_ready_o;
  pipe_pkg::token_t retire_o;
  logic             dmem_req_o;
  logic             dmem_we_o;
  pipe_pkg::word_t  dmem_addr_o;
  pipe_pkg::word_t  dmem_wdata_o;

  entry_t      tab [$];    // stimulus table
  exp_t        exp_q [$];  // retire scoreboard
  access_t     acc_q [$];  // expected handshakes, in order
  int          acc_cyc [256];
  int          cyc = 0;
  int          last_ret = 0;
  logic [31:0] rng = 32'h7e14_8d1a;
  logic [31:0] busy_rng = 32'h7e14_8d1a;  // fetch stall pattern

  pipe_hazard_top uut (
    .clk           (clk),
    .rst           (rst),
    .fetch_i       (fetch_i),
    .imem_busy_i   (imem_busy_i),
    .dmem_ack_i    (dmem_ack_i),
    .dmem_rdata_i  (dmem_rdata_i),
    .fetch_ready_o (fetch_ready_o),
    .retire_o      (retire_o),
    .dmem_req_o    (dmem_req_o),
    .dmem_we_o     (dmem_we_o),
    .dmem_addr_o   (dmem_addr_o),
    .dmem_wdata_o  (dmem_wdata_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;  // edge count

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic string group_name(input logic [2:0] grp);
    case (grp)
      G_ALU:   return "alu_flow";
      G_LU:    return "load_use";
      G_JMP:   return "jump";
      G_MUL:   return "mul";
      G_MEM:   return "mem_handshake";
      default: return "trap";
    endcase
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic check_eq(input string name, input string what,
                          input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act)
      fail_run($sformatf("[ERROR] %s: %s expected %0h, actual %0h", name, what, exp, act));
  endtask

  // one table row, tags count up from 1
  task automatic add(input logic [2:0] grp, input int ret, input int lat, input int gap,
                     input pipe_pkg::op_t op, input int rd, input int rs1, input int rs2,
                     input int taken, input pipe_pkg::word_t opa, input pipe_pkg::word_t opb);
    entry_t e;
    e           = '0;
    e.tok.valid = 1'b1;
    e.tok.tag   = pipe_pkg::tag_t'(tab.size() + 1);
    e.tok.op    = op;
    e.tok.rd    = pipe_pkg::reg_idx_t'(rd);
    e.tok.rs1   = pipe_pkg::reg_idx_t'(rs1);
    e.tok.rs2   = pipe_pkg::reg_idx_t'(rs2);
    e.tok.taken = (taken != 0);
    e.tok.opa   = opa;
    e.tok.opb   = opb;
    e.retires   = (ret != 0);
    e.grp       = grp;
    e.lat       = 8'(lat);
    e.gap       = 8'(gap);
    tab.push_back(e);
  endtask

  task automatic build_table();
    // free flow
    add(G_ALU, 1, 4, 0, pipe_pkg::OP_ALU, 1, 0, 0, 0, 32'h0000_1001, 32'h0);
    add(G_ALU, 1, 4, 0, pipe_pkg::OP_ALU, 2, 0, 0, 0, 32'h0000_1002, 32'h0);
    add(G_ALU, 1, 4, 0, pipe_pkg::OP_ALU, 3, 0, 0, 0, 32'h0000_1003, 32'h0);
    add(G_ALU, 1, 4, 0, pipe_pkg::OP_ALU, 4, 0, 0, 0, 32'h0000_1004, 32'h0);
    // dependent user two cycles behind its load, x0 never waits
    add(G_LU, 1, 0, 0, pipe_pkg::OP_LOAD, 5, 0, 0, 0, 32'h0000_0100, 32'h0);
    add(G_LU, 1, 0, 2, pipe_pkg::OP_ALU, 13, 5, 0, 0, 32'h0000_2001, 32'h0);
    add(G_LU, 1, 0, 0, pipe_pkg::OP_LOAD, 6, 0, 0, 0, 32'h0000_0104, 32'h0);
    add(G_LU, 1, 0, 2, pipe_pkg::OP_ALU, 14, 0, 6, 0, 32'h0000_2002, 32'h0);
    add(G_LU, 1, 0, 0, pipe_pkg::OP_LOAD, 0, 0, 0, 0, 32'h0000_0108, 32'h0);
    add(G_LU, 1, 0, 1, pipe_pkg::OP_ALU, 15, 0, 0, 0, 32'h0000_2003, 32'h0);
    // taken jump drops the next two fetches
    add(G_JMP, 1, 0, 0, pipe_pkg::OP_ALU, 16, 0, 0, 0, 32'h0000_3001, 32'h0);
    add(G_JMP, 1, 0, 0, pipe_pkg::OP_JUMP, 1, 0, 0, 1, 32'h0000_3002, 32'h0);
    add(G_JMP, 0, 0, 0, pipe_pkg::OP_ALU, 17, 0, 0, 0, 32'h0000_3003, 32'h0);
    add(G_JMP, 0, 0, 0, pipe_pkg::OP_ALU, 18, 0, 0, 0, 32'h0000_3004, 32'h0);
    add(G_JMP, 1, 0, 0, pipe_pkg::OP_ALU, 19, 0, 0, 0, 32'h0000_3005, 32'h0);
    add(G_JMP, 1, 0, 0, pipe_pkg::OP_JUMP, 1, 0, 0, 0, 32'h0000_3006, 32'h0);
    add(G_JMP, 1, 0, 0, pipe_pkg::OP_ALU, 20, 0, 0, 0, 32'h0000_3007, 32'h0);
    // back to back multiplies
    add(G_MUL, 1, 0, 0, pipe_pkg::OP_MUL, 9, 0, 0, 0, 32'h1234_5678, 32'h9abc_def1);
    add(G_MUL, 1, 0, 0, pipe_pkg::OP_MUL, 10, 0, 0, 0, 32'hffff_ffff, 32'h0000_0003);
    add(G_MUL, 1, 0, 0, pipe_pkg::OP_ALU, 21, 0, 0, 0, 32'h0000_4001, 32'h0);
    add(G_MUL, 1, 0, 0, pipe_pkg::OP_ALU, 22, 0, 0, 0, 32'h0000_4002, 32'h0);
    // loads and stores under random ack delay and fetch stalls
    add(G_MEM, 1, 0, 0, pipe_pkg::OP_STORE, 0, 0, 0, 0, 32'h0000_0200, 32'hdead_beef);
    add(G_MEM, 1, 0, 0, pipe_pkg::OP_LOAD, 11, 0, 0, 0, 32'h0000_0204, 32'h0);
    add(G_MEM, 1, 0, 0, pipe_pkg::OP_LOAD, 12, 0, 0, 0, 32'h0000_0208, 32'h0);
    add(G_MEM, 1, 0, 0, pipe_pkg::OP_STORE, 0, 0, 0, 0, 32'h0000_020c, 32'h0bad_f00d);
    add(G_MEM, 1, 0, 0, pipe_pkg::OP_ALU, 23, 0, 0, 0, 32'h0000_5001, 32'h0);
    // token right behind the trap sits in ex_mem and still retires
    add(G_TRAP, 1, 0, 0, pipe_pkg::OP_ALU, 24, 0, 0, 0, 32'h0000_6001, 32'h0);
    add(G_TRAP, 1, 0, 0, pipe_pkg::OP_TRAP, 0, 0, 0, 0, 32'h0000_6002, 32'h0);
    add(G_TRAP, 1, 0, 0, pipe_pkg::OP_ALU, 25, 0, 0, 0, 32'h0000_6003, 32'h0);
    add(G_TRAP, 0, 0, 0, pipe_pkg::OP_ALU, 26, 0, 0, 0, 32'h0000_6004, 32'h0);
    add(G_TRAP, 0, 0, 0, pipe_pkg::OP_ALU, 27, 0, 0, 0, 32'h0000_6005, 32'h0);
    add(G_TRAP, 0, 0, 0, pipe_pkg::OP_ALU, 28, 0, 0, 0, 32'h0000_6006, 32'h0);
    add(G_TRAP, 1, 4, 0, pipe_pkg::OP_ALU, 29, 0, 0, 0, 32'h0000_6007, 32'h0);
    add(G_TRAP, 1, 4, 0, pipe_pkg::OP_ALU, 30, 0, 0, 0, 32'h0000_6008, 32'h0);
  endtask

  // scoreboard from the table, results by op
  task automatic build_expect();
    exp_t    e;
    access_t a;
    foreach (tab[i]) begin
      if (tab[i].retires) begin
        e.tag = tab[i].tok.tag;
        e.grp = tab[i].grp;
        e.lat = tab[i].lat;
        e.gap = tab[i].gap;
        case (tab[i].tok.op)
          pipe_pkg::OP_MUL:  e.opa = tab[i].tok.opa * tab[i].tok.opb;  // low word only
          pipe_pkg::OP_LOAD: e.opa = tab[i].tok.opa ^ RDATA_KEY;
          default:           e.opa = tab[i].tok.opa;
        endcase
        exp_q.push_back(e);
        if ((tab[i].tok.op == pipe_pkg::OP_LOAD) || (tab[i].tok.op == pipe_pkg::OP_STORE)) begin
          a.grp   = tab[i].grp;
          a.we    = (tab[i].tok.op == pipe_pkg::OP_STORE);
          a.addr  = tab[i].tok.opa;
          a.wdata = tab[i].tok.opb;
          acc_q.push_back(a);
        end
      end
    end
  endtask

  task automatic check_retire(input pipe_pkg::token_t tok);
    exp_t  e;
    string name;
    if (exp_q.size() == 0) fail_run("a token retired after every expected token was done");
    e    = exp_q.pop_front();
    name = group_name(e.grp);
    check_eq(name, "retire tag", 32'(e.tag), 32'(tok.tag));
    check_eq(name, "result", e.opa, tok.opa);
    // sampled one edge after it shows up
    if (e.lat != 0) check_eq(name, "latency", 32'(e.lat), cyc - acc_cyc[tok.tag] - 1);
    if (e.gap != 0) check_eq(name, "retire gap", 32'(e.gap), cyc - last_ret);
    last_ret = cyc;
  endtask

  always @(posedge clk) begin
    if (!rst && retire_o.valid && !uut.stall[4]) check_retire(retire_o);
  end

  // data memory, four-phase slave
  initial begin : mem_model
    access_t a;
    dmem_ack_i   = 1'b0;
    dmem_rdata_i = '0;
    forever begin
      @(posedge clk);
      if (dmem_req_o) begin
        rng = xorshift32(rng);
        repeat (rng[1:0]) @(posedge clk);  // 0..3 cycles
        if (acc_q.size() == 0) fail_run("data memory request with no access expected");
        a = acc_q.pop_front();
        check_eq(group_name(a.grp), "dmem we", 32'(a.we), 32'(dmem_we_o));
        check_eq(group_name(a.grp), "dmem addr", a.addr, dmem_addr_o);
        if (a.we) check_eq(group_name(a.grp), "dmem wdata", a.wdata, dmem_wdata_o);
        dmem_rdata_i <= dmem_addr_o ^ RDATA_KEY;
        dmem_ack_i   <= 1'b1;
        while (dmem_req_o) @(posedge clk);
        dmem_ack_i <= 1'b0;
      end
    end
  end

  initial begin : watchdog
    int limit;
    @(posedge clk);
    limit = tab.size() * (pipe_pkg::MUL_CYCLES + 10) + 8;  // plus reset
    repeat (limit) @(posedge clk);
    fail_run("timeout, tokens never reached retire");
  end

  initial begin : main
    int idx;
    rst         = 1'b1;
    fetch_i     = '0;
    imem_busy_i = 1'b0;
    build_table();
    build_expect();
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    check_eq("reset", "dmem_req", 32'h0, 32'(dmem_req_o));
    check_eq("reset", "retire valid", 32'h0, 32'(retire_o.valid));
    check_eq("reset", "mul busy", 32'h0, 32'(uut.mul_busy));
    check_eq("reset", "fetch ready", 32'h1, 32'(fetch_ready_o));
    idx = 0;
    fetch_i <= tab[0].tok;
    while (idx < tab.size()) begin
      @(posedge clk);
      if (fetch_ready_o) begin
        acc_cyc[tab[idx].tok.tag] = cyc;  // taken at this edge
        idx++;
        if (idx < tab.size()) fetch_i <= tab[idx].tok;
        else fetch_i <= '0;
      end
      // random fetch stalls only while memory tokens are offered
      busy_rng = xorshift32(busy_rng);
      if ((idx < tab.size()) && (tab[idx].grp == G_MEM)) imem_busy_i <= busy_rng[3];
      else imem_busy_i <= 1'b0;
    end
    while (exp_q.size() != 0) @(posedge clk);
    repeat (8) @(posedge clk);  // room for stray retirements
    if (acc_q.size() != 0) begin
      fail_run("data memory accesses still missing at the end of the run");
    end else begin
      $display("Test OK");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* filelist.f */
pipe_pkg.sv
pipeline_control.sv
load_use_detect.sv
muldiv_iter.sv
dmem_port.sv
stage_regs.sv
pipe_hazard_top.sv
tb_pipe_hazard.sv

/* Makefile */
TOP := tb_pipe_hazard

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f filelist.f -o sim_$(TOP)

run: compile
	./obj_dir/sim_$(TOP)

clean:
	rm -rf obj_dir
